// File: Bender.yml
package:
  name: fcvt

sources:
  - hdl/fcvtPkg.sv
  - hdl/fcvtOperandIf.sv
  - hdl/fcvtUnpack.sv
  - hdl/fcvtAlign.sv
  - hdl/fcvtTop.sv
  - target: simulation
    files:
      - sim/fcvtTb.sv

// File: hdl/fcvtAlign.sv
// *********************************************************************
// fcvt aligner
// Two-stage shifter for the float to integer unit. Stage 1 does the
// range check and a byte shift, stage 2 the bit shift, the negation
// and the final result selection.
// *********************************************************************

`timescale 1ns/10ps
`default_nettype none

module fcvtAlign (
  input  logic          clk,
  input  logic          rst,
  input  logic          en,
  fcvtOperandIf.dst     opnd,
  output logic [63:0]   res,
  output logic          invalid
);

  logic signed [fcvtPkg::expWidth-1:0] limit;
  logic signed [fcvtPkg::expWidth-1:0] shFull;
  logic [5:0]  shAmt;
  logic        tailZero;
  logic        outOfRange;
  logic [63:0] coarse;

  // stage 1 registers.
  logic [63:0]      coarseQ;
  logic [2:0]       fineShQ;
  logic             signQ;
  logic             is32Q;
  logic             oorQ;
  fcvtPkg::cvtClass clsQ;

  logic [63:0] fine;
  logic [63:0] signedVal;
  logic [63:0] resNext;
  logic        invNext;

  // *******************************************************************
  // stage 1: range check and byte shift
  // *******************************************************************

  assign limit = opnd.is32 ? 12'sd31 : 12'sd63;

  // bits that survive truncation below the leading one.
  assign tailZero = opnd.is32 ? (opnd.mant[62:32] == 31'b0) : (opnd.mant[62:0] == 63'b0);

  // at the limit only the most negative value fits.
  assign outOfRange = (opnd.exponent > limit) ||
                      ((opnd.exponent == limit) && !(opnd.sign && tailZero));

  // distance of the leading one from the integer lsb.
  // Only meaningful for exponents 0..63, everything else is caught by
  // the class or the range check.
  assign shFull = 12'sd63 - opnd.exponent;
  assign shAmt  = shFull[5:0];

  assign coarse = opnd.mant >> {shAmt[5:3], 3'b000};

  always_ff @(posedge clk) begin
    if (rst) begin
      clsQ <= fcvtPkg::clsZero;
    end else if (en) begin
      clsQ <= opnd.cls;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      coarseQ <= coarse;
      fineShQ <= shAmt[2:0];
      signQ   <= opnd.sign;
      is32Q   <= opnd.is32;
      oorQ    <= outOfRange;
    end
  end

  // *******************************************************************
  // stage 2: bit shift, negate, select
  // *******************************************************************

  assign fine      = coarseQ >> fineShQ;
  assign signedVal = signQ ? (~fine + 64'd1) : fine;

  always_comb begin
    resNext = 64'b0;
    invNext = 1'b0;
    case (clsQ)
      fcvtPkg::clsSpecial: begin
        resNext = is32Q ? {32'b0, fcvtPkg::indefW} : fcvtPkg::indefL;
        invNext = 1'b1;
      end
      fcvtPkg::clsNormal: begin
        if (oorQ) begin
          resNext = is32Q ? {32'b0, fcvtPkg::indefW} : fcvtPkg::indefL;
          invNext = 1'b1;
        end else if (is32Q) begin
          // upper half of a 32-bit result is always zero.
          resNext = {32'b0, signedVal[31:0]};
        end else begin
          resNext = signedVal;
        end
      end
      default: begin
        resNext = 64'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      invalid <= 1'b0;
    end else if (en) begin
      invalid <= invNext;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      res <= resNext;
    end
  end

  // *******************************************************************
  // assertions
  // *******************************************************************

  // class must be known once reset has been applied.
  clsKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(clsQ));

  // an invalid flag always comes with the indefinite value of some width.
  invalidIndef: assert property (@(posedge clk) disable iff (rst)
    invalid |-> ((res == {32'b0, fcvtPkg::indefW}) || (res == fcvtPkg::indefL)));

endmodule

`default_nettype wire

// File: hdl/fcvtOperandIf.sv
// *********************************************************************
// fcvt operand interface
// One unpacked operand travelling from the unpacker to the aligner.
// *********************************************************************

`timescale 1ns/10ps
`default_nettype none

interface fcvtOperandIf;

  logic                                 sign;
  logic signed [fcvtPkg::expWidth-1:0]  exponent;
  // leading one sits at bit 63.
  logic [63:0]                          mant;
  logic                                 is32;
  fcvtPkg::cvtClass                     cls;

  modport src (
    output sign, exponent, mant, is32, cls
  );

  modport dst (
    input sign, exponent, mant, is32, cls
  );

endinterface

`default_nettype wire

// File: hdl/fcvtPkg.sv
// *********************************************************************
// fcvt package
// Conversion opcodes, operand classes, IEEE format constants and the
// integer-indefinite results shared by the float to integer unit.
// *********************************************************************

`default_nettype none

package fcvtPkg;

  // *******************************************************************
  // opcodes and operand classes
  // *******************************************************************

  // the four supported conversions.
  // Sng/Dbl names the source format, W/L names the 32/64-bit target.
  typedef enum logic [1:0] {
    cvtSngToW = 2'd0,
    cvtSngToL = 2'd1,
    cvtDblToW = 2'd2,
    cvtDblToL = 2'd3
  } cvtOp;

  // operand class after unpacking.
  // clsZero also covers every magnitude below one.
  typedef enum logic [1:0] {
    clsZero    = 2'd0,
    clsNormal  = 2'd1,
    clsSpecial = 2'd2
  } cvtClass;

  // *******************************************************************
  // format constants
  // *******************************************************************

  // signed unbiased exponent, wide enough for the double range.
  parameter int expWidth = 12;

  // exponent biases of the IEEE single and double formats.
  parameter int sngBias = 127;
  parameter int dblBias = 1023;

  // *******************************************************************
  // integer-indefinite results
  // *******************************************************************

  // only the sign bit of the target width set.
  parameter logic [31:0] indefW = 32'h8000_0000;
  parameter logic [63:0] indefL = 64'h8000_0000_0000_0000;

endpackage

`default_nettype wire

// File: hdl/fcvtTop.sv
// *********************************************************************
// fcvt top level
// Float to integer conversion unit with valid/ready ports. Tracks the
// two pipeline stages and stalls both under output back-pressure.
// *********************************************************************

`timescale 1ns/10ps
`default_nettype none

module fcvtTop (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValid,
  output logic            inReady,
  input  fcvtPkg::cvtOp   inOp,
  input  logic [63:0]     inData,
  output logic            outValid,
  input  logic            outReady,
  output logic [63:0]     outData,
  output logic            outInvalid
);

  logic advance;
  logic s1Valid;
  logic s2Valid;

  fcvtOperandIf opnd ();

  // *******************************************************************
  // pipeline control
  // *******************************************************************

  // the pipe moves when the output slot is free or being taken.
  assign advance = !s2Valid || outReady;
  assign inReady = advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
    end else if (advance) begin
      s1Valid <= inValid;
      s2Valid <= s1Valid;
    end
  end

  assign outValid = s2Valid;

  // *******************************************************************
  // datapath
  // *******************************************************************

  fcvtUnpack unpack (
    .op   (inOp),
    .data (inData),
    .opnd (opnd.src)
  );

  fcvtAlign align (
    .clk     (clk),
    .rst     (rst),
    .en      (advance),
    .opnd    (opnd.dst),
    .res     (outData),
    .invalid (outInvalid)
  );

  // held result must not move until it is taken.
  outHold: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> $stable(outData));

endmodule

`default_nettype wire

// File: hdl/fcvtUnpack.sv
// *********************************************************************
// fcvt unpacker
// Splits a single or double operand into sign, unbiased exponent and a
// left-justified mantissa, and classifies it for the aligner.
// Purely combinational.
// *********************************************************************

`timescale 1ns/10ps
`default_nettype none

module fcvtUnpack (
  input  fcvtPkg::cvtOp   op,
  input  logic [63:0]     data,
  fcvtOperandIf.src       opnd
);

  logic        isDbl;
  logic [10:0] expField;
  logic [10:0] expBias;
  logic        expZero;
  logic        expOnes;
  logic signed [fcvtPkg::expWidth-1:0] unbiased;

  // *******************************************************************
  // opcode decode
  // *******************************************************************

  assign isDbl = (op == fcvtPkg::cvtDblToW) || (op == fcvtPkg::cvtDblToL);
  assign opnd.is32 = (op == fcvtPkg::cvtSngToW) || (op == fcvtPkg::cvtDblToW);

  // *******************************************************************
  // field selection
  // *******************************************************************

  // single operands live in the low word.
  always_comb begin
    if (isDbl) begin
      opnd.sign = data[63];
      expField  = data[62:52];
      expBias   = 11'(fcvtPkg::dblBias);
      expZero   = (data[62:52] == 11'h000);
      expOnes   = (data[62:52] == 11'h7ff);
      // hidden one on top, fraction below, zero fill.
      opnd.mant = {1'b1, data[51:0], 11'b0};
    end else begin
      opnd.sign = data[31];
      expField  = {3'b000, data[30:23]};
      expBias   = 11'(fcvtPkg::sngBias);
      expZero   = (data[30:23] == 8'h00);
      expOnes   = (data[30:23] == 8'hff);
      opnd.mant = {1'b1, data[22:0], 40'b0};
    end
  end

  // remove the bias.
  // Both operands are non-negative 11-bit values, so 12 signed bits hold
  // the difference for either format.
  assign unbiased = signed'({1'b0, expField}) - signed'({1'b0, expBias});
  assign opnd.exponent = unbiased;

  // *******************************************************************
  // classification
  // *******************************************************************

  // denormals and anything below one truncate to zero.
  always_comb begin
    if (expOnes) begin
      opnd.cls = fcvtPkg::clsSpecial;
    end else if (expZero || (unbiased < 0)) begin
      opnd.cls = fcvtPkg::clsZero;
    end else begin
      opnd.cls = fcvtPkg::clsNormal;
    end
  end

endmodule

`default_nettype wire

// File: sim/fcvtTb.sv
// *********************************************************************
// fcvt testbench
// Drives the float to integer unit through a table of known cases and
// LFSR random operands with output stalls, and checks every result.
// *********************************************************************

`timescale 1ns/10ps
`default_nettype none

module fcvtTb;

  localparam int clkPeriod    = 100;
  localparam int numVec       = 25;
  localparam int numRand      = 200;
  localparam int totalOps     = 2 * numVec + numRand;
  localparam int timeoutLimit = 4 * totalOps + 50;

  typedef struct packed {
    logic [1:0]    grp;
    fcvtPkg::cvtOp op;
    logic [63:0]   data;
    logic [63:0]   expRes;
    logic          expInv;
  } vecT;

  typedef struct packed {
    logic [63:0] res;
    logic        inv;
    logic        is32;
    logic [63:0] t;
  } pendT;

  // group 0 exact integers, group 1 small magnitudes, group 2 specials and range.
  localparam vecT vecTable [numVec] = '{
    '{2'd0, fcvtPkg::cvtSngToW, 64'h00000000_3F800000, 64'h00000000_00000001, 1'b0},
    '{2'd0, fcvtPkg::cvtSngToW, 64'h00000000_BF800000, 64'h00000000_FFFFFFFF, 1'b0},
    '{2'd0, fcvtPkg::cvtSngToL, 64'h00000000_BF800000, 64'hFFFFFFFF_FFFFFFFF, 1'b0},
    '{2'd0, fcvtPkg::cvtSngToW, 64'h00000000_42F78000, 64'h00000000_0000007B, 1'b0},
    '{2'd0, fcvtPkg::cvtSngToL, 64'h00000000_C2F78000, 64'hFFFFFFFF_FFFFFF85, 1'b0},
    '{2'd0, fcvtPkg::cvtDblToL, 64'hC05EF000_00000000, 64'hFFFFFFFF_FFFFFF85, 1'b0},
    '{2'd0, fcvtPkg::cvtDblToW, 64'h41DFFFFF_FFC00000, 64'h00000000_7FFFFFFF, 1'b0},
    '{2'd0, fcvtPkg::cvtDblToL, 64'h41DFFFFF_FFC00000, 64'h00000000_7FFFFFFF, 1'b0},
    '{2'd0, fcvtPkg::cvtSngToW, 64'h00000000_C0200000, 64'h00000000_FFFFFFFE, 1'b0},
    '{2'd1, fcvtPkg::cvtSngToW, 64'h00000000_00000000, 64'h00000000_00000000, 1'b0},
    '{2'd1, fcvtPkg::cvtSngToL, 64'h00000000_80000000, 64'h00000000_00000000, 1'b0},
    '{2'd1, fcvtPkg::cvtSngToW, 64'h00000000_00000001, 64'h00000000_00000000, 1'b0},
    '{2'd1, fcvtPkg::cvtDblToL, 64'h800FFFFF_FFFFFFFF, 64'h00000000_00000000, 1'b0},
    '{2'd1, fcvtPkg::cvtDblToW, 64'hBFEFFFFF_FFFFFFFF, 64'h00000000_00000000, 1'b0},
    '{2'd2, fcvtPkg::cvtSngToW, 64'h00000000_7F800000, 64'h00000000_80000000, 1'b1},
    '{2'd2, fcvtPkg::cvtSngToL, 64'h00000000_FF800000, 64'h80000000_00000000, 1'b1},
    '{2'd2, fcvtPkg::cvtDblToW, 64'h7FF80000_00000000, 64'h00000000_80000000, 1'b1},
    '{2'd2, fcvtPkg::cvtSngToW, 64'h00000000_4F000000, 64'h00000000_80000000, 1'b1},
    '{2'd2, fcvtPkg::cvtSngToW, 64'h00000000_CF000000, 64'h00000000_80000000, 1'b0},
    '{2'd2, fcvtPkg::cvtDblToW, 64'hC1E00000_00100000, 64'h00000000_80000000, 1'b0},
    '{2'd2, fcvtPkg::cvtDblToW, 64'hC1E00000_00200000, 64'h00000000_80000000, 1'b1},
    '{2'd2, fcvtPkg::cvtDblToL, 64'hC3E00000_00000000, 64'h80000000_00000000, 1'b0},
    '{2'd2, fcvtPkg::cvtDblToL, 64'h43E00000_00000000, 64'h80000000_00000000, 1'b1},
    '{2'd2, fcvtPkg::cvtSngToL, 64'h00000000_DF000000, 64'h80000000_00000000, 1'b0},
    '{2'd2, fcvtPkg::cvtSngToW, 64'h00000000_501502F9, 64'h00000000_80000000, 1'b1}
  };

  logic          clk = 1'b0;
  logic          rst;
  logic          inValid;
  logic          inReady;
  fcvtPkg::cvtOp inOp;
  logic [63:0]   inData;
  logic          outValid;
  logic          outReady;
  logic [63:0]   outData;
  logic          outInvalid;

  pendT        pendQ [$];
  logic [31:0] lfsr = 32'h2c60e47b;
  logic        strictLat = 1'b1;
  logic        stallMode = 1'b0;
  logic        holdPrev = 1'b0;
  logic [63:0] prevData;
  logic        prevInv;
  int          checks = 0;
  int          errors = 0;
  int          cycle = 0;

  always #(clkPeriod / 2) clk = ~clk;

  fcvtTop UUT (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inReady    (inReady),
    .inOp       (inOp),
    .inData     (inData),
    .outValid   (outValid),
    .outReady   (outReady),
    .outData    (outData),
    .outInvalid (outInvalid)
  );

  // *******************************************************************
  // random source and reference model
  // *******************************************************************

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    logic        fb;
    v = 64'b0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  // returns {invalid, result} by scaling the significand to an integer.
  function automatic logic [64:0] convertModel(input fcvtPkg::cvtOp op, input logic [63:0] data);
    logic         dbl;
    logic         to32;
    logic         sign;
    int           expField;
    int           expMax;
    int           bias;
    int           fracBits;
    int           width;
    int           unbiased;
    logic [127:0] sig;
    logic [127:0] mag;
    logic [127:0] edgeMag;
    logic [63:0]  indef;
    logic [63:0]  val;
    dbl   = (op == fcvtPkg::cvtDblToW) || (op == fcvtPkg::cvtDblToL);
    to32  = (op == fcvtPkg::cvtSngToW) || (op == fcvtPkg::cvtDblToW);
    width = to32 ? 32 : 64;
    indef = to32 ? {32'b0, fcvtPkg::indefW} : fcvtPkg::indefL;
    if (dbl) begin
      sign     = data[63];
      expField = int'(data[62:52]);
      expMax   = 2047;
      bias     = fcvtPkg::dblBias;
      fracBits = 52;
      sig      = {75'b0, 1'b1, data[51:0]};
    end else begin
      sign     = data[31];
      expField = int'(data[30:23]);
      expMax   = 255;
      bias     = fcvtPkg::sngBias;
      fracBits = 23;
      sig      = {104'b0, 1'b1, data[22:0]};
    end
    unbiased = expField - bias;
    if (expField == expMax) return {1'b1, indef};
    if (expField == 0 || unbiased < 0) return 65'b0;
    if (unbiased >= width) return {1'b1, indef};
    if (unbiased >= fracBits) begin
      mag = sig << (unbiased - fracBits);
    end else begin
      mag = sig >> (fracBits - unbiased);
    end
    // only a negative value may reach 2^(width-1).
    edgeMag = 128'd1 << (width - 1);
    if (mag > edgeMag || (mag == edgeMag && !sign)) return {1'b1, indef};
    val = sign ? (~mag[63:0] + 64'd1) : mag[63:0];
    if (to32) val[63:32] = 32'b0;
    return {1'b0, val};
  endfunction

  // *******************************************************************
  // driver tasks
  // *******************************************************************

  task automatic updateReady();
    outReady = stallMode ? (randBits(2) != 64'd0) : 1'b1;
  endtask

  // offers one operand and waits for its acceptance edge.
  task automatic issue(input fcvtPkg::cvtOp op, input logic [63:0] data,
                       input logic [63:0] expRes, input logic expInv);
    logic accepted;
    pendT p;
    inValid  = 1'b1;
    inOp     = op;
    inData   = data;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = inReady;
      if (strictLat) begin
        assert (inReady) else begin
          $display("error at %0t: operand was not accepted in the cycle it was offered", $time);
          errors++;
        end
      end
      if (accepted) begin
        p.res  = expRes;
        p.inv  = expInv;
        p.is32 = (op == fcvtPkg::cvtSngToW) || (op == fcvtPkg::cvtDblToW);
        p.t    = $time;
        pendQ.push_back(p);
      end
      #1;
      updateReady();
    end
  endtask

  task automatic drain();
    inValid = 1'b0;
    while (pendQ.size() != 0) begin
      @(posedge clk);
      #1;
      updateReady();
    end
  endtask

  task automatic report(input string name, input int c0, input int e0);
    $display("test %s: %0d results checked, %0d errors", name, checks - c0, errors - e0);
  endtask

  // group 3 replays the whole table back to back.
  task automatic runTable(input int grp, input string name);
    int c0;
    int e0;
    c0        = checks;
    e0        = errors;
    strictLat = 1'b1;
    stallMode = 1'b0;
    outReady  = 1'b1;
    for (int i = 0; i < numVec; i++) begin
      if (grp == 3 || vecTable[i].grp == 2'(grp)) begin
        issue(vecTable[i].op, vecTable[i].data, vecTable[i].expRes, vecTable[i].expInv);
      end
    end
    drain();
    report(name, c0, e0);
  endtask

  // exponents from just below one up to well past the 64-bit range.
  task automatic runRandom();
    int            c0;
    int            e0;
    fcvtPkg::cvtOp op;
    logic          sign;
    logic [6:0]    expOff;
    logic          special;
    logic [63:0]   data;
    logic [64:0]   modelOut;
    c0        = checks;
    e0        = errors;
    strictLat = 1'b0;
    stallMode = 1'b1;
    for (int i = 0; i < numRand; i++) begin
      op      = fcvtPkg::cvtOp'(2'(randBits(2)));
      sign    = 1'(randBits(1));
      expOff  = 7'(randBits(7));
      special = (randBits(3) == 64'd0);
      if (op == fcvtPkg::cvtDblToW || op == fcvtPkg::cvtDblToL) begin
        data[63]    = sign;
        data[62:52] = special ? 11'h7ff : 11'(fcvtPkg::dblBias - 4 + int'(expOff));
        data[51:0]  = 52'(randBits(52));
      end else begin
        data[63:32] = 32'(randBits(32));
        data[31]    = sign;
        data[30:23] = special ? 8'hff : 8'(fcvtPkg::sngBias - 4 + int'(expOff));
        data[22:0]  = 23'(randBits(23));
      end
      modelOut = convertModel(op, data);
      issue(op, data, modelOut[63:0], modelOut[64]);
    end
    drain();
    stallMode = 1'b0;
    outReady  = 1'b1;
    report("random with back-pressure", c0, e0);
  endtask

  // *******************************************************************
  // output monitor
  // *******************************************************************

  always @(posedge clk) begin
    pendT p;
    if (!rst) begin
      if (holdPrev) begin
        assert (outValid && outData == prevData && outInvalid == prevInv) else begin
          $display("MISMATCH at %0t: output moved while stalled, data %h", $time, outData);
          errors++;
        end
      end
      if (outValid && outReady) begin
        if (pendQ.size() == 0) begin
          $display("error at %0t: a result arrived with no operation pending", $time);
          errors++;
        end else begin
          p = pendQ.pop_front();
          checks++;
          assert (outData == p.res && outInvalid == p.inv) else begin
            $display("MISMATCH at %0t: got %h inv %b, expected %h inv %b",
                     $time, outData, outInvalid, p.res, p.inv);
            errors++;
          end
          assert (!p.is32 || outData[63:32] == 32'b0) else begin
            $display("MISMATCH at %0t: upper half %h on a 32-bit result", $time, outData[63:32]);
            errors++;
          end
          if (strictLat) begin
            assert ($time == p.t + 2 * clkPeriod) else begin
              $display("MISMATCH at %0t: result accepted at %0t came late", $time, p.t);
              errors++;
            end
          end else begin
            assert ($time >= p.t + 2 * clkPeriod) else begin
              $display("MISMATCH at %0t: result accepted at %0t came early", $time, p.t);
              errors++;
            end
          end
        end
      end
      holdPrev = outValid && !outReady;
      prevData = outData;
      prevInv  = outInvalid;
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= timeoutLimit) begin
      $display("timeout: results stopped arriving, %0d operations still pending", pendQ.size());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // *******************************************************************
  // test sequence
  // *******************************************************************

  initial begin
    rst      = 1'b1;
    inValid  = 1'b0;
    inOp     = fcvtPkg::cvtSngToW;
    inData   = 64'b0;
    outReady = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    runTable(0, "exact integers");
    runTable(1, "small magnitudes");
    runTable(2, "specials and range");
    runRandom();
    runTable(3, "latency and throughput");
    // any stray result would show up here.
    repeat (5) @(posedge clk);
    #1;
    $display("%0d results checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/fcvtPkg.sv
hdl/fcvtOperandIf.sv
hdl/fcvtUnpack.sv
hdl/fcvtAlign.sv
hdl/fcvtTop.sv
sim/fcvtTb.sv
